// ==== tb/fx2_cases.txt ====
# name op fmt rt ra rb reg_write branch rand ra_odd rb_odd ra_even rb_even rc_even
#   exp_stall_odd exp_stall_even exp_value exp_rt exp_write (all hex, rand=1 randomizes ra and rb)
shlh_lanes 05F 0 01 12351235123512351235123512351235 0000000100040008000F0010001F0021 1 0 0 7f 7f 7f 7f 7f 0 0 1235246A23503500800000000000246A 01 1
roth_lanes 05C 0 02 12351235123512351235123512351235 000000040008000C001000110003FFFF 1 0 0 01 7f 7f 7f 7f 1 0 12352351351251231235246A91A8891A 02 1
rothm_lanes 05D 0 03 86428642864286428642864286428642 0000FFFFFFFCFFF8FFF1FFF00001001F 1 0 0 7f 01 7f 7f 7f 1 0 86424321086400860001000000004321 03 1
rotmah_neg 05E 0 04 86428642864286428642864286428642 0000FFFFFFFCFFF8FFF1FFF00001001F 1 0 0 7f 7f 01 7f 7f 0 1 8642C321F864FF86FFFFFFFFFFFFC321 04 1
rotmah_pos 05E 0 05 46424642464246424642464246424642 0000FFFFFFFCFFF8FFF1FFF00001001F 1 0 0 7f 7f 7f 01 7f 0 0 46422321046400460000000000002321 05 1
shl_lanes 05B 0 06 80000001800000018000000180000001 000000010000001F0000002000000041 1 0 0 7f 7f 7f 7f 03 0 1 00000002800000000000000000000002 06 1
rot_lanes 058 0 07 80000001800000018000000180000001 0000000100000004000000200000003F 1 0 0 06 7f 7f 7f 05 1 1 000000030000001880000001C0000000 07 1
rotm_lanes 059 0 08 80000001800000018000000180000001 FFFFFFFFFFFFFFE1FFFFFFE000000000 1 0 0 04 7f 7f 7f 7f 0 0 40000000000000010000000080000001 08 1
rotma_lanes 05A 0 09 80000001800000018000000180000001 FFFFFFFFFFFFFFE1FFFFFFE000000000 1 0 0 7f 7f 7f 7f 7f 0 0 C0000000FFFFFFFFFFFFFFFF80000001 09 1
branch_flush 05B 0 0A 0 0 1 1 1 7f 7f 09 07 7f 0 1 0 00 0
nop_empty 000 0 0B 0 0 1 0 1 7f 08 7f 7f 7f 1 0 0 00 0
unknown_op 7FF 0 0C 0 0 1 0 1 7f 0A 00 7f 7f 0 0 0 00 0
format_one 05B 1 0D 0 0 1 0 1 7f 7f 7f 7f 7f 0 0 0 00 0
shl_nowrite 05B 0 0E 0 0 0 0 0 0A 7f 00 7f 7f 0 0 0 0E 0
nowrite_src 05D 0 0F 86428642864286428642864286428642 0 1 0 0 0E 7f 7f 0E 7f 0 0 86428642864286428642864286428642 0F 1
roth_by_one 05C 0 10 86428642864286428642864286428642 00010001000100010001000100010001 1 0 0 0F 7f 7f 7f 0D 1 0 0C850C850C850C850C850C850C850C85 10 1
shl_last 05B 0 11 80000001800000018000000180000001 00000001000000010000000100000001 1 0 0 7f 0E 10 7f 7f 0 1 00000002000000020000000200000002 11 1

// ==== files.f ====
src/fx2_pkg.sv
src/fx2_decode.sv
src/fx2_halfword_unit.sv
src/fx2_word_unit.sv
src/fx2_result_pipe.sv
src/fx2_raw_hazard.sv
src/simple_fixed2.sv
tb/tb_simple_fixed2.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_simple_fixed2 -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
	exit 0
fi
echo "pass message not found"
exit 1

// ==== tb/tb_simple_fixed2.sv ====
`timescale 1ns/1ps

module tb_simple_fixed2
	import fx2_pkg::*;
();

	logic clk;
	logic reset;
	opcode_t op;
	format_t format;
	reg_addr_t rt_addr;
	quad_t ra;
	quad_t rb;
	logic reg_write;
	logic branch_taken;
	reg_addr_t ra_odd_addr;
	reg_addr_t rb_odd_addr;
	reg_addr_t ra_even_addr;
	reg_addr_t rb_even_addr;
	reg_addr_t rc_even_addr;
	quad_t rt_wb;
	reg_addr_t rt_addr_wb;
	logic reg_write_wb;
	logic stall_odd_raw;
	logic stall_even_raw;

	// one entry per case line
	string case_name[$];
	logic [10:0] case_op[$];
	logic [2:0] case_fmt[$];
	logic [6:0] case_rt[$];
	logic [127:0] case_ra[$];
	logic [127:0] case_rb[$];
	logic case_wr[$];
	logic case_br[$];
	logic case_rnd[$];
	logic [6:0] case_src[$][5];
	logic case_so[$];
	logic case_se[$];
	logic [127:0] case_val[$];
	logic [6:0] case_exp_rt[$];
	logic case_exp_wr[$];

	// write-back expectations waiting for their instruction to drain
	string wb_name[$];
	logic [127:0] wb_val[$];
	logic [6:0] wb_rt[$];
	logic wb_wr[$];

	int cycle_count;
	int cycle_limit;

	simple_fixed2 i_simple_fixed2 (
		.clk(clk),
		.reset(reset),
		.op(op),
		.format(format),
		.rt_addr(rt_addr),
		.ra(ra),
		.rb(rb),
		.reg_write(reg_write),
		.branch_taken(branch_taken),
		.ra_odd_addr(ra_odd_addr),
		.rb_odd_addr(rb_odd_addr),
		.ra_even_addr(ra_even_addr),
		.rb_even_addr(rb_even_addr),
		.rc_even_addr(rc_even_addr),
		.rt_wb(rt_wb),
		.rt_addr_wb(rt_addr_wb),
		.reg_write_wb(reg_write_wb),
		.stall_odd_raw(stall_odd_raw),
		.stall_even_raw(stall_even_raw)
	);

	// 8 ns period
	initial clk = 1'b0;
	always #4 clk = ~clk;

	// run length guard
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run went past %0d cycles without finishing", cycle_limit);
			$display("Result: FAILED");
			$fatal(1);
		end
	end

	task automatic check_value(input string test, input string what,
		input logic [127:0] expected, input logic [127:0] actual);
		if (expected !== actual) begin
			$display("FAIL %0s %0s: expected %h, actual %h", test, what, expected, actual);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	// idle inputs with the sources on a register nothing writes
	task automatic drive_idle();
		op = '0;
		format = '0;
		rt_addr = '0;
		ra = '0;
		rb = '0;
		reg_write = 1'b0;
		branch_taken = 1'b0;
		ra_odd_addr = 7'h7f;
		rb_odd_addr = 7'h7f;
		ra_even_addr = 7'h7f;
		rb_even_addr = 7'h7f;
		rc_even_addr = 7'h7f;
	endtask

	task automatic drive_line(input int k);
		op = case_op[k];
		format = case_fmt[k];
		rt_addr = case_rt[k];
		reg_write = case_wr[k];
		branch_taken = case_br[k];
		ra_odd_addr = case_src[k][0];
		rb_odd_addr = case_src[k][1];
		ra_even_addr = case_src[k][2];
		rb_even_addr = case_src[k][3];
		rc_even_addr = case_src[k][4];
		// don't-care operands get random data
		if (case_rnd[k]) begin
			ra = {$urandom(), $urandom(), $urandom(), $urandom()};
			rb = {$urandom(), $urandom(), $urandom(), $urandom()};
		end else begin
			ra = case_ra[k];
			rb = case_rb[k];
		end
	endtask

	// compare the oldest expectation with the write-back outputs
	task automatic check_writeback();
		string nm;
		nm = wb_name.pop_front();
		check_value(nm, "rt_wb", wb_val.pop_front(), rt_wb);
		check_value(nm, "rt_addr_wb", 128'(wb_rt.pop_front()), 128'(rt_addr_wb));
		check_value(nm, "reg_write_wb", 128'(wb_wr.pop_front()), 128'(reg_write_wb));
	endtask

	// stage 3 still holds a cleared entry
	task automatic check_empty_writeback(input string test);
		check_value(test, "rt_wb", '0, rt_wb);
		check_value(test, "rt_addr_wb", '0, 128'(rt_addr_wb));
		check_value(test, "reg_write_wb", '0, 128'(reg_write_wb));
	endtask

	task automatic check_empty_outputs(input string test);
		check_empty_writeback(test);
		check_value(test, "stall_odd_raw", '0, 128'(stall_odd_raw));
		check_value(test, "stall_even_raw", '0, 128'(stall_even_raw));
	endtask

	task automatic load_cases();
		int fd;
		int got;
		string line;
		string nm;
		logic [10:0] t_op;
		logic [2:0] t_fmt;
		logic [6:0] t_rt;
		logic [127:0] t_ra;
		logic [127:0] t_rb;
		logic t_wr;
		logic t_br;
		logic t_rnd;
		logic [6:0] t_src[5];
		logic t_so;
		logic t_se;
		logic [127:0] t_val;
		logic [6:0] t_ert;
		logic t_ewr;
		fd = $fopen("tb/fx2_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file tb/fx2_cases.txt");
			$display("Result: FAILED");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			got = $fgets(line, fd);
			// skip blank lines and the column description
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				nm, t_op, t_fmt, t_rt, t_ra, t_rb, t_wr, t_br, t_rnd,
				t_src[0], t_src[1], t_src[2], t_src[3], t_src[4],
				t_so, t_se, t_val, t_ert, t_ewr);
			if (got != 19) begin
				$display("malformed line in the case file: %0s", line);
				$display("Result: FAILED");
				$fatal(1);
			end
			case_name.push_back(nm);
			case_op.push_back(t_op);
			case_fmt.push_back(t_fmt);
			case_rt.push_back(t_rt);
			case_ra.push_back(t_ra);
			case_rb.push_back(t_rb);
			case_wr.push_back(t_wr);
			case_br.push_back(t_br);
			case_rnd.push_back(t_rnd);
			case_src.push_back(t_src);
			case_so.push_back(t_so);
			case_se.push_back(t_se);
			case_val.push_back(t_val);
			case_exp_rt.push_back(t_ert);
			case_exp_wr.push_back(t_ewr);
		end
		$fclose(fd);
	endtask

	initial begin
		void'($urandom(83));
		cycle_count = 0;
		cycle_limit = 1000;
		reset = 1'b1;
		drive_idle();
		load_cases();
		// reset and the drain fit inside the margin
		cycle_limit = case_name.size() + 20;

		// pipe must stay empty through reset
		repeat (3) begin
			@(posedge clk);
			#1;
			check_empty_outputs("reset");
		end

		for (int k = 0; k < case_name.size(); k++) begin
			@(negedge clk);
			reset = 1'b0;
			drive_line(k);
			// settle point before the next rising edge
			#3;
			check_value(case_name[k], "stall_odd_raw", 128'(case_so[k]), 128'(stall_odd_raw));
			check_value(case_name[k], "stall_even_raw", 128'(case_se[k]), 128'(stall_even_raw));
			wb_name.push_back(case_name[k]);
			wb_val.push_back(case_val[k]);
			wb_rt.push_back(case_exp_rt[k]);
			wb_wr.push_back(case_exp_wr[k]);
			// four cycles from presentation to write-back
			if (wb_name.size() > PIPE_DEPTH)
				check_writeback();
			else
				check_empty_writeback("after_reset");
		end

		// drain the last instructions
		while (wb_name.size() > 0) begin
			@(negedge clk);
			drive_idle();
			#3;
			check_writeback();
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== src/simple_fixed2.sv ====
`timescale 1ns/1ps

module simple_fixed2
	import fx2_pkg::*;
(
	input logic clk,
	input logic reset,
	input opcode_t op,
	input format_t format,
	input reg_addr_t rt_addr,
	input quad_t ra,
	input quad_t rb,
	input logic reg_write,
	input logic branch_taken,
	input reg_addr_t ra_odd_addr,
	input reg_addr_t rb_odd_addr,
	input reg_addr_t ra_even_addr,
	input reg_addr_t rb_even_addr,
	input reg_addr_t rc_even_addr,
	output quad_t rt_wb,
	output reg_addr_t rt_addr_wb,
	output logic reg_write_wb,
	output logic stall_odd_raw,
	output logic stall_even_raw
);

	// decode outputs
	logic is_half;
	shift_kind_t kind;
	logic entry_valid;

	// both lane widths are computed, the pipe picks one
	quad_t half_result;
	quad_t word_result;

	// in-flight destinations for the hazard check
	reg_addr_t [HAZARD_STAGES-1:0] stage_addr;
	logic [HAZARD_STAGES-1:0] stage_write;

	fx2_decode i_decode (
		.op(op),
		.format(format),
		.branch_taken(branch_taken),
		.is_half(is_half),
		.kind(kind),
		.entry_valid(entry_valid)
	);

	fx2_halfword_unit i_halfword_unit (
		.ra(ra),
		.rb(rb),
		.kind(kind),
		.result(half_result)
	);

	fx2_word_unit i_word_unit (
		.ra(ra),
		.rb(rb),
		.kind(kind),
		.result(word_result)
	);

	fx2_result_pipe i_result_pipe (
		.clk(clk),
		.reset(reset),
		.entry_valid(entry_valid),
		.is_half(is_half),
		.half_result(half_result),
		.word_result(word_result),
		.rt_addr(rt_addr),
		.reg_write(reg_write),
		.rt_wb(rt_wb),
		.rt_addr_wb(rt_addr_wb),
		.reg_write_wb(reg_write_wb),
		.stage_addr(stage_addr),
		.stage_write(stage_write)
	);

	fx2_raw_hazard i_raw_hazard (
		.reset(reset),
		.stage_addr(stage_addr),
		.stage_write(stage_write),
		.ra_odd_addr(ra_odd_addr),
		.rb_odd_addr(rb_odd_addr),
		.ra_even_addr(ra_even_addr),
		.rb_even_addr(rb_even_addr),
		.rc_even_addr(rc_even_addr),
		.stall_odd_raw(stall_odd_raw),
		.stall_even_raw(stall_even_raw)
	);

endmodule

// ==== src/fx2_raw_hazard.sv ====
`timescale 1ns/1ps

module fx2_raw_hazard
	import fx2_pkg::*;
(
	input logic reset,
	input reg_addr_t [HAZARD_STAGES-1:0] stage_addr,
	input logic [HAZARD_STAGES-1:0] stage_write,
	input reg_addr_t ra_odd_addr,
	input reg_addr_t rb_odd_addr,
	input reg_addr_t ra_even_addr,
	input reg_addr_t rb_even_addr,
	input reg_addr_t rc_even_addr,
	output logic stall_odd_raw,
	output logic stall_even_raw
);

	always_comb begin
		stall_odd_raw = 1'b0;
		stall_even_raw = 1'b0;

		// only stages that will write can create a hazard
		for (int s = 0; s < HAZARD_STAGES; s++) begin
			if (stage_write[s]) begin
				// odd slot reads two sources
				if ((stage_addr[s] == ra_odd_addr) || (stage_addr[s] == rb_odd_addr)) begin
					stall_odd_raw = 1'b1;
				end
				// even slot reads up to three
				if ((stage_addr[s] == ra_even_addr) ||
					(stage_addr[s] == rb_even_addr) ||
					(stage_addr[s] == rc_even_addr)) begin
					stall_even_raw = 1'b1;
				end
			end
		end

		// issue logic ignores hazards while the core is in reset
		if (reset) begin
			stall_odd_raw = 1'b0;
			stall_even_raw = 1'b0;
		end
	end

endmodule

// ==== src/fx2_result_pipe.sv ====
`timescale 1ns/1ps

module fx2_result_pipe
	import fx2_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic entry_valid,
	input logic is_half,
	input quad_t half_result,
	input quad_t word_result,
	input reg_addr_t rt_addr,
	input logic reg_write,
	output quad_t rt_wb,
	output reg_addr_t rt_addr_wb,
	output logic reg_write_wb,
	output reg_addr_t [HAZARD_STAGES-1:0] stage_addr,
	output logic [HAZARD_STAGES-1:0] stage_write
);

	// entry per stage, index 0 is the execute stage
	quad_t [PIPE_DEPTH-1:0] stage_value;
	reg_addr_t [PIPE_DEPTH-1:0] stage_addr_q;
	logic [PIPE_DEPTH-1:0] stage_write_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_value <= '0;
			stage_addr_q <= '0;
			stage_write_q <= '0;
		end else begin
			// stage 0 takes the new instruction or an empty entry
			if (entry_valid) begin
				stage_value[0] <= is_half ? half_result : word_result;
				stage_addr_q[0] <= rt_addr;
				stage_write_q[0] <= reg_write;
			end else begin
				stage_value[0] <= '0;
				stage_addr_q[0] <= '0;
				stage_write_q[0] <= 1'b0;
			end
			// no back-pressure, everything moves every cycle
			for (int s = 1; s < PIPE_DEPTH; s++) begin
				stage_value[s] <= stage_value[s-1];
				stage_addr_q[s] <= stage_addr_q[s-1];
				stage_write_q[s] <= stage_write_q[s-1];
			end
		end
	end

	// last stage feeds write-back
	assign rt_wb = stage_value[PIPE_DEPTH-1];
	assign rt_addr_wb = stage_addr_q[PIPE_DEPTH-1];
	assign reg_write_wb = stage_write_q[PIPE_DEPTH-1];

	// stages still in flight go to the hazard check
	assign stage_addr = stage_addr_q[HAZARD_STAGES-1:0];
	assign stage_write = stage_write_q[HAZARD_STAGES-1:0];

endmodule

// ==== src/fx2_word_unit.sv ====
`timescale 1ns/1ps

module fx2_word_unit
	import fx2_pkg::*;
(
	input quad_t ra,
	input quad_t rb,
	input shift_kind_t kind,
	output quad_t result
);

	// one word lane, count taken from the same lane of rb
	function automatic word_t word_lane(input word_t a, input word_t b, input shift_kind_t k);
		logic [5:0] cnt;
		logic [4:0] rot_cnt;
		logic [5:0] neg_cnt;
		logic [0:63] doubled;
		word_t r;
		// low 6 bits for shift left
		cnt = b[26:31];
		// rotate count modulo 32
		rot_cnt = b[27:31];
		// negated count for the right shifts
		neg_cnt = 6'd0 - b[26:31];
		doubled = {a, a} << rot_cnt;
		case (k)
			KIND_SHL: begin
				r = (cnt >= 6'd32) ? '0 : (a << cnt);
			end
			KIND_ROT: begin
				// bits shifted out of the top wrap in from the copy
				r = doubled[0:31];
			end
			KIND_ROTM: begin
				r = (neg_cnt >= 6'd32) ? '0 : (a >> neg_cnt);
			end
			default: begin
				// sign fill, count of 32 or more gives all sign bits
				if (neg_cnt >= 6'd32)
					r = {32{a[0]}};
				else
					r = $signed(a) >>> neg_cnt;
			end
		endcase
		return r;
	endfunction

	always_comb begin
		// four lanes, each with its own count
		for (int i = 0; i < WORD_LANES; i++) begin
			result[i*$bits(word_t) +: $bits(word_t)] =
				word_lane(ra[i*$bits(word_t) +: $bits(word_t)],
					rb[i*$bits(word_t) +: $bits(word_t)], kind);
		end
	end

endmodule

// ==== src/fx2_halfword_unit.sv ====
`timescale 1ns/1ps

module fx2_halfword_unit
	import fx2_pkg::*;
(
	input quad_t ra,
	input quad_t rb,
	input shift_kind_t kind,
	output quad_t result
);

	// one halfword lane, count taken from the same lane of rb
	function automatic half_t half_lane(input half_t a, input half_t b, input shift_kind_t k);
		logic [4:0] cnt;
		logic [3:0] rot_cnt;
		logic [4:0] neg_cnt;
		logic [0:31] doubled;
		half_t r;
		// low 5 bits for shift left
		cnt = b[11:15];
		// rotate only needs the count modulo 16
		rot_cnt = b[12:15];
		// right shifts use the two's complement of the count
		neg_cnt = 5'd0 - b[11:15];
		doubled = {a, a} << rot_cnt;
		case (k)
			KIND_SHL: begin
				r = (cnt >= 5'd16) ? '0 : (a << cnt);
			end
			KIND_ROT: begin
				// upper half of the shifted pair is the rotated lane
				r = doubled[0:15];
			end
			KIND_ROTM: begin
				r = (neg_cnt >= 5'd16) ? '0 : (a >> neg_cnt);
			end
			default: begin
				// algebraic, large counts leave only sign copies
				if (neg_cnt >= 5'd16)
					r = {16{a[0]}};
				else
					r = $signed(a) >>> neg_cnt;
			end
		endcase
		return r;
	endfunction

	always_comb begin
		// lanes are independent, lane 0 sits at the msb end
		for (int i = 0; i < HALF_LANES; i++) begin
			result[i*$bits(half_t) +: $bits(half_t)] =
				half_lane(ra[i*$bits(half_t) +: $bits(half_t)],
					rb[i*$bits(half_t) +: $bits(half_t)], kind);
		end
	end

endmodule

// ==== src/fx2_decode.sv ====
`timescale 1ns/1ps

module fx2_decode
	import fx2_pkg::*;
(
	input opcode_t op,
	input format_t format,
	input logic branch_taken,
	output logic is_half,
	output shift_kind_t kind,
	output logic entry_valid
);

	always_comb begin
		// defaults describe an empty entry
		is_half = 1'b0;
		kind = KIND_SHL;
		entry_valid = 1'b0;

		case (op)
			OP_SHLH: begin
				is_half = 1'b1;
				kind = KIND_SHL;
				entry_valid = 1'b1;
			end
			OP_SHL: begin
				kind = KIND_SHL;
				entry_valid = 1'b1;
			end
			OP_ROTH: begin
				is_half = 1'b1;
				kind = KIND_ROT;
				entry_valid = 1'b1;
			end
			OP_ROT: begin
				kind = KIND_ROT;
				entry_valid = 1'b1;
			end
			OP_ROTHM: begin
				is_half = 1'b1;
				kind = KIND_ROTM;
				entry_valid = 1'b1;
			end
			OP_ROTM: begin
				kind = KIND_ROTM;
				entry_valid = 1'b1;
			end
			OP_ROTMAH: begin
				is_half = 1'b1;
				kind = KIND_ROTMA;
				entry_valid = 1'b1;
			end
			OP_ROTMA: begin
				kind = KIND_ROTMA;
				entry_valid = 1'b1;
			end
			// nop (op 0) and unknown opcodes stay empty
			default: entry_valid = 1'b0;
		endcase

		// a taken branch flushes, and only the rr format belongs here
		if (branch_taken || (format != FMT_RR)) begin
			entry_valid = 1'b0;
		end
	end

endmodule

// ==== src/fx2_pkg.sv ====
package fx2_pkg;

	// register value, bit 0 is the msb as in the rest of the core
	typedef logic [0:127] quad_t;

	// lane views of a register value
	typedef logic [0:15] half_t;
	typedef logic [0:31] word_t;

	// register file address
	typedef logic [0:6] reg_addr_t;

	// instruction fields from the issue stage
	typedef logic [0:10] opcode_t;
	typedef logic [2:0] format_t;

	// operation class shared by both lane units
	typedef logic [1:0] shift_kind_t;

	localparam shift_kind_t KIND_SHL = 2'd0;
	localparam shift_kind_t KIND_ROT = 2'd1;
	// rotate and mask, logical right shift by the negated count
	localparam shift_kind_t KIND_ROTM = 2'd2;
	// rotate and mask algebraic, sign fill
	localparam shift_kind_t KIND_ROTMA = 2'd3;

	// register-register format
	localparam format_t FMT_RR = 3'd0;

	// register-form shift and rotate opcodes
	localparam opcode_t OP_SHLH = 11'b00001011111;
	localparam opcode_t OP_SHL = 11'b00001011011;
	localparam opcode_t OP_ROTH = 11'b00001011100;
	localparam opcode_t OP_ROT = 11'b00001011000;
	localparam opcode_t OP_ROTHM = 11'b00001011101;
	localparam opcode_t OP_ROTM = 11'b00001011001;
	localparam opcode_t OP_ROTMAH = 11'b00001011110;
	localparam opcode_t OP_ROTMA = 11'b00001011010;

	localparam int HALF_LANES = 8;
	localparam int WORD_LANES = 4;

	// execute to write-back depth
	localparam int PIPE_DEPTH = 4;
	// stages 0 to 2 still hold results not yet written back
	localparam int HAZARD_STAGES = 3;

endpackage
